//--- tb.f
design/hub75_geom_pkg.sv
design/hub75_timing_pkg.sv
design/hub75_fb_rd_if.sv
design/hub75_framebuffer.sv
design/hub75_scan.sv
design/hub75_bcm.sv
design/hub75_shift.sv
design/hub75_blanking.sv
design/hub75_top.sv
tests/hub75_chk.sv
tests/hub75_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module hub75_tb -f tb.f -o hub75_sim
./obj_dir/hub75_sim

//--- tests/hub75_tb.sv
module hub75_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import hub75_geom_pkg::*;
	import hub75_timing_pkg::*;

	localparam int BANK_W = (N_BANKS_DEF > 1) ? $clog2(N_BANKS_DEF) : 1;
	localparam int ROW_W = (N_ROWS_DEF > 1) ? $clog2(N_ROWS_DEF) : 1;
	localparam int COL_W = (N_COLS_DEF > 1) ? $clog2(N_COLS_DEF) : 1;
	localparam int PIX_W = N_CHANS_DEF * N_PLANES_DEF;	// channel-major pixel word
	localparam int OUT_W = N_BANKS_DEF * N_CHANS_DEF;
	localparam int PRE_LEN = 2;
	localparam int LATCH_LEN = 3;
	localparam int POST_LEN = 2;
	localparam int BIT_LEN = 4;
	localparam int N_FRAMES = 8;	// startup frame, A frames, B frames, partial ones
	localparam longint PLANE_MAX = 2 * N_COLS_DEF + PRE_LEN + LATCH_LEN + POST_LEN + BIT_LEN
		+ 255 * 2 ** (N_PLANES_DEF - 1);
	localparam longint WATCHDOG_NS = longint'(N_FRAMES) * N_ROWS_DEF * N_PLANES_DEF
		* PLANE_MAX * 100 + 400000;	// margin for reset and image loads

	logic clk = 1'b0;
	logic rst;
	logic [BANK_W-1:0] fbw_bank;
	logic [ROW_W-1:0] fbw_row;
	logic [COL_W-1:0] fbw_col;
	logic [PIX_W-1:0] fbw_data;
	logic fbw_wren;
	logic frame_swap;
	logic frame_rdy;
	logic [ROW_W-1:0] hub75_addr;
	logic [OUT_W-1:0] hub75_data;
	logic hub75_clk;
	logic hub75_le;
	logic hub75_blank;

	logic [PIX_W-1:0] img [2][N_BANKS_DEF][N_ROWS_DEF][N_COLS_DEF];	// A and B
	int unsigned lcg_state;
	int front_img;			// -1 while the front frame is unknown
	int back_img;			// image behind the next swap
	int frames_done [2];	// complete frames checked per image
	int swaps_seen;
	logic [OUT_W-1:0] cols [$];	// columns shifted since the last latch
	int trk_row;
	int trk_plane;
	int disp_plane;			// plane now on display
	int le_len;
	int blank_len;
	int latch_cnt;
	int disp_cnt;
	logic prev_hclk;
	logic prev_le;
	logic prev_blank;
	logic prev_frdy;

	always #50 clk = ~clk;

	hub75_top #(
		.N_BANKS(N_BANKS_DEF), .N_ROWS(N_ROWS_DEF), .N_COLS(N_COLS_DEF),
		.N_CHANS(N_CHANS_DEF), .N_PLANES(N_PLANES_DEF)
	) dut (
		.clk(clk), .rst(rst), .fbw_bank(fbw_bank), .fbw_row(fbw_row), .fbw_col(fbw_col),
		.fbw_data(fbw_data), .fbw_wren(fbw_wren), .frame_swap(frame_swap),
		.frame_rdy(frame_rdy), .cfg_pre_latch_len(CFG_W'(PRE_LEN)),
		.cfg_latch_len(CFG_W'(LATCH_LEN)), .cfg_post_latch_len(CFG_W'(POST_LEN)),
		.cfg_bcm_bit_len(CFG_W'(BIT_LEN)), .hub75_addr(hub75_addr), .hub75_data(hub75_data),
		.hub75_clk(hub75_clk), .hub75_le(hub75_le), .hub75_blank(hub75_blank));

	bind hub75_bcm hub75_chk chk (.clk(clk), .rst(rst), .le(hub75_le),
		.shift_go(shift_go), .shift_rdy(shift_rdy), .blank_go(blank_go), .blank_rdy(blank_rdy));

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;	// low bits of an lcg cycle too fast
	endfunction

	// panel word for one column: bank-major, then channel, one plane bit each
	function automatic logic [OUT_W-1:0] ref_data(int sel, int row, int col, int plane);
		logic [OUT_W-1:0] word;
		word = '0;
		for (int b = 0; b < N_BANKS_DEF; b++) begin
			for (int c = 0; c < N_CHANS_DEF; c++) begin
				word[b*N_CHANS_DEF + c] = img[sel][b][row][col][c*N_PLANES_DEF + plane];
			end
		end
		return word;
	endfunction

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_idle_outputs();
		check_eq(hub75_blank, 1, "blank while idle");
		check_eq(hub75_le, 0, "le while idle");
		check_eq(hub75_clk, 0, "panel clock while idle");
		check_eq(frame_rdy, 1, "frame_rdy while idle");
	endtask

	task automatic load_image(input int sel);
		for (int b = 0; b < N_BANKS_DEF; b++) begin
			for (int r = 0; r < N_ROWS_DEF; r++) begin
				for (int c = 0; c < N_COLS_DEF; c++) begin
					@(negedge clk);
					fbw_bank = BANK_W'(b);
					fbw_row = ROW_W'(r);
					fbw_col = COL_W'(c);
					fbw_data = img[sel][b][r][c];
					fbw_wren = 1'b1;
				end
			end
		end
		@(negedge clk);
		fbw_wren = 1'b0;
	endtask

	task automatic swap_to(input int sel);
		back_img = sel;
		@(negedge clk);
		frame_swap = 1'b1;
		@(negedge clk);
		frame_swap = 1'b0;
		check_eq(frame_rdy, 0, "frame_rdy after swap request");
		while (!frame_rdy) @(negedge clk);	// watchdog bounds this
	endtask

	// panel monitor, outputs settle after posedge
	always @(negedge clk) begin
		if (!rst) begin
			if (hub75_clk && !prev_hclk) cols.push_back(hub75_data);
			if (hub75_le && !prev_le) begin
				check_eq(disp_cnt, latch_cnt, "latch before previous display ended");
				le_len = 0;
			end
			if (hub75_le) begin
				le_len++;
				check_eq(hub75_addr, trk_row, "hub75_addr during latch");
			end
			if (!hub75_le && prev_le) begin
				check_eq(le_len, LATCH_LEN, "le pulse length");
				check_eq(cols.size(), N_COLS_DEF, "panel clocks per plane");
				if (front_img >= 0) begin
					for (int c = 0; c < N_COLS_DEF; c++) begin
						check_eq(cols[c], ref_data(front_img, trk_row, c, trk_plane),
							$sformatf("hub75_data row %0d col %0d plane %0d",
							trk_row, c, trk_plane));
					end
				end
				cols.delete();
				disp_plane = trk_plane;
				latch_cnt++;
				if (trk_plane == N_PLANES_DEF - 1) begin
					trk_plane = 0;
					if (trk_row == N_ROWS_DEF - 1) begin	// frame complete
						trk_row = 0;
						if (front_img >= 0) frames_done[front_img]++;
					end else begin
						trk_row++;
					end
				end else begin
					trk_plane++;
				end
			end
			if (!hub75_blank && prev_blank) begin
				check_eq(disp_cnt + 1, latch_cnt, "display without a fresh latch");
				blank_len = 0;
			end
			if (!hub75_blank) blank_len++;
			if (hub75_blank && !prev_blank) begin
				check_eq(blank_len, BIT_LEN << disp_plane, "blank low length");
				disp_cnt++;
			end
			if (frame_rdy && !prev_frdy) begin	// swap landed a cycle ago
				check_eq(trk_row * N_PLANES_DEF + trk_plane, 0, "swap off frame boundary");
				front_img = back_img;
				swaps_seen++;
			end
		end
		prev_hclk = hub75_clk;
		prev_le = hub75_le;
		prev_blank = hub75_blank;
		prev_frdy = frame_rdy;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Result: FAILED");
		$fatal(1, "watchdog expired before the panel showed all expected frames");
	end

	initial begin
		rst = 1'b1;
		fbw_bank = '0;
		fbw_row = '0;
		fbw_col = '0;
		fbw_data = '0;
		fbw_wren = 1'b0;
		frame_swap = 1'b0;
		lcg_state = 97;
		front_img = -1;
		back_img = -1;
		frames_done[0] = 0;
		frames_done[1] = 0;
		swaps_seen = 0;
		trk_row = 0;
		trk_plane = 0;
		disp_plane = 0;
		le_len = 0;
		blank_len = 0;
		latch_cnt = 0;
		disp_cnt = 0;
		prev_hclk = 1'b0;
		prev_le = 1'b0;
		prev_blank = 1'b1;
		prev_frdy = 1'b1;
		for (int s = 0; s < 2; s++) begin
			for (int b = 0; b < N_BANKS_DEF; b++) begin
				for (int r = 0; r < N_ROWS_DEF; r++) begin
					for (int c = 0; c < N_COLS_DEF; c++) begin
						img[s][b][r][c] = PIX_W'(lcg_next());
					end
				end
			end
		end
		repeat (16) begin
			@(negedge clk);
			check_idle_outputs();
		end
		rst = 1'b0;
		@(negedge clk);
		check_idle_outputs();				// scan just started, panel still dark
		load_image(0);
		swap_to(0);
		while (frames_done[0] < 2) @(negedge clk);
		load_image(1);						// A keeps scanning meanwhile
		swap_to(1);
		while (frames_done[1] < 2) @(negedge clk);
		check_eq(swaps_seen, 2, "frame swaps applied");
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- tests/hub75_chk.sv
module hub75_chk (
	input logic clk,
	input logic rst,
	input logic le,
	input logic shift_go,
	input logic shift_rdy,
	input logic blank_go,
	input logic blank_rdy
);

	timeunit 1ns;
	timeprecision 1ps;

	// blanking is busy exactly while blank is low
	le_dark: assert property (@(posedge clk) disable iff (rst) le |-> blank_rdy)
		else $error("latch enable high while the panel is lit");

	blank_go_idle: assert property (@(posedge clk) disable iff (rst) blank_go |-> blank_rdy)
		else $error("blanking started while still busy");

	shift_go_idle: assert property (@(posedge clk) disable iff (rst) shift_go |-> shift_rdy)
		else $error("shift started while still busy");

endmodule

//--- design/hub75_top.sv
module hub75_top #(
	parameter int N_BANKS = hub75_geom_pkg::N_BANKS_DEF,
	parameter int N_ROWS = hub75_geom_pkg::N_ROWS_DEF,
	parameter int N_COLS = hub75_geom_pkg::N_COLS_DEF,
	parameter int N_CHANS = hub75_geom_pkg::N_CHANS_DEF,
	parameter int N_PLANES = hub75_geom_pkg::N_PLANES_DEF,
	localparam int BANK_W = (N_BANKS > 1) ? $clog2(N_BANKS) : 1,
	localparam int ROW_W = (N_ROWS > 1) ? $clog2(N_ROWS) : 1,
	localparam int COL_W = (N_COLS > 1) ? $clog2(N_COLS) : 1,
	localparam int PW = (N_PLANES > 1) ? $clog2(N_PLANES) : 1
) (
	input logic clk,
	input logic rst,
	input logic [BANK_W-1:0] fbw_bank,
	input logic [ROW_W-1:0] fbw_row,
	input logic [COL_W-1:0] fbw_col,
	input logic [N_CHANS*N_PLANES-1:0] fbw_data,
	input logic fbw_wren,
	input logic frame_swap,
	output logic frame_rdy,
	input logic [hub75_timing_pkg::CFG_W-1:0] cfg_pre_latch_len,
	input logic [hub75_timing_pkg::CFG_W-1:0] cfg_latch_len,
	input logic [hub75_timing_pkg::CFG_W-1:0] cfg_post_latch_len,
	input logic [hub75_timing_pkg::CFG_W-1:0] cfg_bcm_bit_len,
	output logic [ROW_W-1:0] hub75_addr,
	output logic [N_BANKS*N_CHANS-1:0] hub75_data,
	output logic hub75_clk,
	output logic hub75_le,
	output logic hub75_blank
);

	logic swap_pending;				// request seen, waiting for end of frame
	logic swap_fb;
	logic scan_go, scan_rdy;
	logic [ROW_W-1:0] bcm_row;
	logic bcm_go, bcm_rdy;
	logic [ROW_W-1:0] shift_row;
	logic [PW-1:0] shift_plane, blank_plane;
	logic shift_go, shift_rdy, blank_go, blank_rdy;

	hub75_fb_rd_if #(.N_BANKS(N_BANKS), .N_ROWS(N_ROWS), .N_COLS(N_COLS),
		.N_CHANS(N_CHANS), .N_PLANES(N_PLANES)) fb_rd ();

	always_ff @(posedge clk or posedge rst) begin
		if (rst) swap_pending <= 1'b0;
		else swap_pending <= (swap_pending & ~scan_rdy) | (frame_swap & ~swap_pending);
	end

	assign frame_rdy = ~swap_pending;
	assign swap_fb = swap_pending & scan_rdy;		// frame boundary
	assign scan_go = scan_rdy & ~swap_pending;		// hold scan until the swap lands

	hub75_framebuffer #(.N_BANKS(N_BANKS), .N_ROWS(N_ROWS), .N_COLS(N_COLS),
		.N_CHANS(N_CHANS), .N_PLANES(N_PLANES)) fb_i (
		.clk(clk), .rst(rst), .wr_bank(fbw_bank), .wr_row(fbw_row), .wr_col(fbw_col),
		.wr_data(fbw_data), .wr_en(fbw_wren), .frame_swap(swap_fb), .rd(fb_rd.mem));

	hub75_scan #(.N_ROWS(N_ROWS)) scan_i (
		.clk(clk), .rst(rst), .go(scan_go), .rdy(scan_rdy),
		.bcm_row(bcm_row), .bcm_go(bcm_go), .bcm_rdy(bcm_rdy));

	hub75_bcm #(.N_ROWS(N_ROWS), .N_PLANES(N_PLANES)) bcm_i (
		.clk(clk), .rst(rst), .go(bcm_go), .row(bcm_row), .rdy(bcm_rdy),
		.shift_row(shift_row), .shift_plane(shift_plane), .shift_go(shift_go),
		.shift_rdy(shift_rdy), .blank_plane(blank_plane), .blank_go(blank_go),
		.blank_rdy(blank_rdy), .cfg_pre_latch_len(cfg_pre_latch_len),
		.cfg_latch_len(cfg_latch_len), .cfg_post_latch_len(cfg_post_latch_len),
		.hub75_addr(hub75_addr), .hub75_le(hub75_le));

	hub75_shift #(.N_BANKS(N_BANKS), .N_ROWS(N_ROWS), .N_COLS(N_COLS),
		.N_CHANS(N_CHANS), .N_PLANES(N_PLANES)) shift_i (
		.clk(clk), .rst(rst), .go(shift_go), .row(shift_row), .plane(shift_plane),
		.rdy(shift_rdy), .fb(fb_rd.reader), .hub75_data(hub75_data),
		.hub75_clk(hub75_clk));

	hub75_blanking #(.N_PLANES(N_PLANES)) blank_i (
		.clk(clk), .rst(rst), .go(blank_go), .plane(blank_plane), .rdy(blank_rdy),
		.cfg_bcm_bit_len(cfg_bcm_bit_len), .hub75_blank(hub75_blank));

endmodule

//--- design/hub75_blanking.sv
module hub75_blanking #(
	parameter int N_PLANES = hub75_geom_pkg::N_PLANES_DEF,
	localparam int PW = (N_PLANES > 1) ? $clog2(N_PLANES) : 1
) (
	input logic clk,
	input logic rst,
	input logic go,
	input logic [PW-1:0] plane,
	output logic rdy,
	input logic [hub75_timing_pkg::CFG_W-1:0] cfg_bcm_bit_len,
	output logic hub75_blank
);

	import hub75_timing_pkg::*;

	localparam int LEN_W = CFG_W + N_PLANES;	// room for bit_len << (N_PLANES-1)

	logic [LEN_W-1:0] len;
	logic [LEN_W-1:0] cnt;		// display cycles left

	assign len = {{N_PLANES{1'b0}}, cfg_bcm_bit_len} << plane;	// weight 2^plane
	assign rdy = (cnt == '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
			hub75_blank <= 1'b1;	// panel dark out of reset
		end else if (go) begin
			cnt <= len;
			hub75_blank <= (len == '0);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
			if (cnt == LEN_W'(1)) hub75_blank <= 1'b1;	// back high with rdy
		end
	end

endmodule

//--- design/hub75_shift.sv
module hub75_shift #(
	parameter int N_BANKS = hub75_geom_pkg::N_BANKS_DEF,
	parameter int N_ROWS = hub75_geom_pkg::N_ROWS_DEF,
	parameter int N_COLS = hub75_geom_pkg::N_COLS_DEF,
	parameter int N_CHANS = hub75_geom_pkg::N_CHANS_DEF,
	parameter int N_PLANES = hub75_geom_pkg::N_PLANES_DEF,
	localparam int ROW_W = (N_ROWS > 1) ? $clog2(N_ROWS) : 1,
	localparam int COL_W = (N_COLS > 1) ? $clog2(N_COLS) : 1,
	localparam int PW = (N_PLANES > 1) ? $clog2(N_PLANES) : 1,
	localparam int CW = $clog2(2 * N_COLS + 2)
) (
	input logic clk,
	input logic rst,
	input logic go,
	input logic [ROW_W-1:0] row,
	input logic [PW-1:0] plane,
	output logic rdy,
	hub75_fb_rd_if.reader fb,
	output logic [N_BANKS*N_CHANS-1:0] hub75_data,	// bank-major, then channel
	output logic hub75_clk
);

	logic active;
	logic [CW-1:0] cnt;			// two counts per column plus read latency
	logic [ROW_W-1:0] row_r;
	logic [PW-1:0] plane_r;
	logic odd;

	assign odd = cnt[0];
	assign rdy = ~active;
	assign fb.row = row_r;
	assign fb.column = cnt[COL_W:1];
	assign fb.rden = active && !odd && (cnt < CW'(2 * N_COLS));	// even counts read

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			cnt <= '0;
			row_r <= '0;
			plane_r <= '0;
			hub75_data <= '0;
			hub75_clk <= 1'b0;
		end else begin
			if (go && !active) begin
				active <= 1'b1;
				cnt <= '0;
				row_r <= row;
				plane_r <= plane;
			end else if (active) begin
				cnt <= cnt + 1'b1;
				if (cnt == CW'(2 * N_COLS + 1)) active <= 1'b0;	// last clock pulse out
			end
			if (active && odd && (cnt < CW'(2 * N_COLS))) begin	// pixel arrived
				for (int i = 0; i < N_BANKS * N_CHANS; i++) begin
					hub75_data[i] <= fb.data[i*N_PLANES + int'(plane_r)];
				end
			end
			hub75_clk <= active && !odd && (cnt >= CW'(2));	// rise one cycle after data
		end
	end

endmodule

//--- design/hub75_bcm.sv
module hub75_bcm #(
	parameter int N_ROWS = hub75_geom_pkg::N_ROWS_DEF,
	parameter int N_PLANES = hub75_geom_pkg::N_PLANES_DEF,
	localparam int ROW_W = (N_ROWS > 1) ? $clog2(N_ROWS) : 1,
	localparam int PW = (N_PLANES > 1) ? $clog2(N_PLANES) : 1
) (
	input logic clk,
	input logic rst,
	input logic go,
	input logic [ROW_W-1:0] row,
	output logic rdy,
	output logic [ROW_W-1:0] shift_row,
	output logic [PW-1:0] shift_plane,
	output logic shift_go,
	input logic shift_rdy,
	output logic [PW-1:0] blank_plane,
	output logic blank_go,
	input logic blank_rdy,
	input logic [hub75_timing_pkg::CFG_W-1:0] cfg_pre_latch_len,
	input logic [hub75_timing_pkg::CFG_W-1:0] cfg_latch_len,
	input logic [hub75_timing_pkg::CFG_W-1:0] cfg_post_latch_len,
	output logic [ROW_W-1:0] hub75_addr,
	output logic hub75_le
);

	import hub75_timing_pkg::*;

	bcm_state_t state;
	logic [ROW_W-1:0] row_r;
	logic [PW-1:0] plane;
	logic [CFG_W-1:0] cnt;			// shared by pre, latch and post gaps
	logic last_plane;

	assign last_plane = (plane == PW'(N_PLANES - 1));
	assign rdy = (state == BCM_IDLE);
	assign shift_row = row_r;
	assign shift_plane = plane;		// next plane already shifting while this one shows
	assign blank_plane = plane;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= BCM_IDLE;
			row_r <= '0;
			plane <= '0;
			cnt <= '0;
			shift_go <= 1'b0;
			blank_go <= 1'b0;
			hub75_addr <= '0;
			hub75_le <= 1'b0;
		end else begin
			shift_go <= 1'b0;		// go strobes last one cycle
			blank_go <= 1'b0;
			case (state)
				BCM_IDLE: if (go) begin
					row_r <= row;
					plane <= '0;
					shift_go <= 1'b1;
					state <= BCM_SHIFT;
				end
				BCM_SHIFT: if (!shift_go && shift_rdy && blank_rdy) begin	// skip go cycle
					cnt <= cfg_pre_latch_len;
					state <= BCM_PRE;
				end
				BCM_PRE: if (cnt == '0) begin
					hub75_le <= 1'b1;
					hub75_addr <= row_r;	// address moves with the latch
					cnt <= cfg_latch_len - CFG_W'(1);
					state <= BCM_LATCH;
				end else begin
					cnt <= cnt - 1'b1;
				end
				BCM_LATCH: if (cnt == '0) begin
					hub75_le <= 1'b0;
					cnt <= cfg_post_latch_len;
					state <= BCM_POST;
				end else begin
					cnt <= cnt - 1'b1;
				end
				BCM_POST: if (cnt == '0) begin
					blank_go <= 1'b1;		// blanking was idle, checked in shift
					state <= BCM_DISP;
				end else begin
					cnt <= cnt - 1'b1;
				end
				BCM_DISP: if (last_plane) begin
					state <= BCM_IDLE;		// row done, display still running
				end else begin
					plane <= plane + 1'b1;
					shift_go <= 1'b1;
					state <= BCM_SHIFT;
				end
				default: state <= BCM_IDLE;
			endcase
		end
	end

endmodule

//--- design/hub75_scan.sv
module hub75_scan #(
	parameter int N_ROWS = hub75_geom_pkg::N_ROWS_DEF,
	localparam int ROW_W = (N_ROWS > 1) ? $clog2(N_ROWS) : 1
) (
	input logic clk,
	input logic rst,
	input logic go,					// start one full frame
	output logic rdy,
	output logic [ROW_W-1:0] bcm_row,
	output logic bcm_go,
	input logic bcm_rdy
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_GO = 2'd1;		// hand next row to bcm
	localparam logic [1:0] S_WAIT = 2'd2;	// bcm busy on the row

	logic [1:0] state;
	logic [ROW_W-1:0] row_cnt;
	logic last_row;

	assign last_row = (row_cnt == ROW_W'(N_ROWS - 1));
	assign rdy = (state == S_IDLE);
	assign bcm_row = row_cnt;
	assign bcm_go = (state == S_GO) && bcm_rdy;	// never while bcm is busy

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			row_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: if (go) begin
					row_cnt <= '0;
					state <= S_GO;
				end
				S_GO: if (bcm_rdy) state <= S_WAIT;	// go leaves this cycle
				S_WAIT: if (bcm_rdy) begin			// low until the row is done
					if (last_row) begin
						state <= S_IDLE;
					end else begin
						row_cnt <= row_cnt + 1'b1;
						state <= S_GO;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

//--- design/hub75_framebuffer.sv
module hub75_framebuffer #(
	parameter int N_BANKS = hub75_geom_pkg::N_BANKS_DEF,
	parameter int N_ROWS = hub75_geom_pkg::N_ROWS_DEF,
	parameter int N_COLS = hub75_geom_pkg::N_COLS_DEF,
	parameter int N_CHANS = hub75_geom_pkg::N_CHANS_DEF,
	parameter int N_PLANES = hub75_geom_pkg::N_PLANES_DEF,
	localparam int BANK_W = (N_BANKS > 1) ? $clog2(N_BANKS) : 1,
	localparam int ROW_W = (N_ROWS > 1) ? $clog2(N_ROWS) : 1,
	localparam int COL_W = (N_COLS > 1) ? $clog2(N_COLS) : 1,
	localparam int PIX_W = N_CHANS * N_PLANES
) (
	input logic clk,
	input logic rst,
	input logic [BANK_W-1:0] wr_bank,
	input logic [ROW_W-1:0] wr_row,
	input logic [COL_W-1:0] wr_col,
	input logic [PIX_W-1:0] wr_data,
	input logic wr_en,
	input logic frame_swap,		// one cycle, only when scan is idle
	hub75_fb_rd_if.mem rd
);

	logic [PIX_W-1:0] mem [2][N_BANKS][N_ROWS][N_COLS];	// [frame][bank][row][col]
	logic front;										// frame shown on the panel
	logic back;

	assign back = ~front;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			front <= 1'b0;
		end else if (frame_swap) begin
			front <= ~front;			// back becomes visible
		end
	end

	// writer only ever sees the back frame
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[back][wr_bank][wr_row][wr_col] <= wr_data;
		end
	end

	// all banks read together, one pixel word each
	always_ff @(posedge clk) begin
		if (rd.rden) begin
			for (int b = 0; b < N_BANKS; b++) begin
				rd.data[b*PIX_W +: PIX_W] <= mem[front][b][rd.row][rd.column];
			end
		end
	end

endmodule

//--- design/hub75_fb_rd_if.sv
interface hub75_fb_rd_if #(
	parameter int N_BANKS = hub75_geom_pkg::N_BANKS_DEF,
	parameter int N_ROWS = hub75_geom_pkg::N_ROWS_DEF,
	parameter int N_COLS = hub75_geom_pkg::N_COLS_DEF,
	parameter int N_CHANS = hub75_geom_pkg::N_CHANS_DEF,
	parameter int N_PLANES = hub75_geom_pkg::N_PLANES_DEF
);

	localparam int ROW_W = (N_ROWS > 1) ? $clog2(N_ROWS) : 1;
	localparam int COL_W = (N_COLS > 1) ? $clog2(N_COLS) : 1;

	logic [ROW_W-1:0] row;							// row inside every bank
	logic [COL_W-1:0] column;
	logic rden;										// data follows one cycle later
	logic [N_BANKS*N_CHANS*N_PLANES-1:0] data;		// bank b at b*N_CHANS*N_PLANES

	modport reader (output row, output column, output rden, input data);
	modport mem (input row, input column, input rden, output data);

endinterface

//--- design/hub75_timing_pkg.sv
package hub75_timing_pkg;

	localparam int CFG_W = 8;	// width of every timing config field

	// bcm sequencer, one pass of shift..disp per bit plane
	typedef enum logic [2:0] {
		BCM_IDLE = 3'd0,	// waiting for a row from scan
		BCM_SHIFT = 3'd1,	// shift running, then wait for blanking idle
		BCM_PRE = 3'd2,		// gap before latch
		BCM_LATCH = 3'd3,	// le high
		BCM_POST = 3'd4,	// gap after latch
		BCM_DISP = 3'd5		// blanking go issued
	} bcm_state_t;

endpackage

//--- design/hub75_geom_pkg.sv
package hub75_geom_pkg;

	// default panel geometry, overridden through the top parameters

	localparam int N_BANKS_DEF = 2;		// rows driven in parallel
	localparam int N_ROWS_DEF = 4;		// rows per bank, power of two
	localparam int N_COLS_DEF = 8;		// pixels per shifted line
	localparam int N_CHANS_DEF = 3;		// r, g, b
	localparam int N_PLANES_DEF = 4;	// bcm bit planes per channel

	// pixel word is channel-major:
	// bit c*N_PLANES + p holds plane p of channel c

endpackage
